/* project.f */
logic/core_shell_pkg.sv
logic/core_wake_ctrl.sv
logic/icache_scramble_ctrl.sv
logic/core_shell_top.sv
testbench/tb_clock_gen.sv
testbench/tb_core_shell.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --assert
TOP       ?= tb_core_shell
FILELIST  ?= project.f

OBJ_DIR   := obj_dir
SIM_BIN   := $(OBJ_DIR)/V$(TOP)

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "TESTBENCH PASSED"

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* testbench/tb_core_shell.sv */
// Testbench for the core shell
// Random stimulus from a fixed seed, reference model of wake control,
// key exchange and alert merge, compare tasks and error reporting

`timescale 1ns/1ps

module tb_core_shell;

  import core_shell_pkg::*;

  localparam int unsigned RESET_CYCLES    = 5;
  localparam int unsigned DIRECTED_CYCLES = 20;
  localparam int unsigned RUN_CYCLES      = 2000;
  localparam int unsigned TIMEOUT_CYCLES  = RUN_CYCLES + 100;

  // Everything the DUT receives in one cycle
  typedef struct packed {
    logic       core_busy;
    wake_t      wake;
    logic       test_en;
    logic       icache_inval;
    logic       alert_minor;
    logic       alert_major;
    alert_t     lockstep_alert;
    logic       key_valid;
    scr_key_t   key;
    scr_nonce_t nonce;
  } stim_t;

  logic       clk_i;
  logic       rst_ni;
  stim_t      stim;
  logic       clk_en;
  logic       core_sleep;
  logic       scr_req;
  scr_cfg_t   scr_cfg;
  alert_t     alert;

  int         seed = 32'hc43e_59ef;
  int         err_cnt = 0;
  int         check_cnt = 0;
  int         cycle_cnt = 0;

  // Reference model state
  logic       model_busy_q;
  logic       model_req;
  scr_cfg_t   model_cfg;

  // Event counts for the key exchange
  int         req_opened = 0;
  int         keys_in_req = 0;
  int         keys_outside = 0;

  tb_clock_gen u_clock_gen (
    .clk_o(clk_i)
  );

  core_shell_top i_core_shell_top (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .core_busy_i       (stim.core_busy),
    .wake_i            (stim.wake),
    .test_en_i         (stim.test_en),
    .icache_inval_i    (stim.icache_inval),
    .core_alert_minor_i(stim.alert_minor),
    .core_alert_major_i(stim.alert_major),
    .lockstep_alert_i  (stim.lockstep_alert),
    .scr_key_valid_i   (stim.key_valid),
    .scr_key_i         (stim.key),
    .scr_nonce_i       (stim.nonce),
    .clk_en_o          (clk_en),
    .core_sleep_o      (core_sleep),
    .scr_req_o         (scr_req),
    .scr_cfg_o         (scr_cfg),
    .alert_o           (alert)
  );

  ////////////////////////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////////////////////////

  task automatic check_bit(input logic got, input logic exp, input string what);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: %s is %b, expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_alert(input alert_t got, input alert_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: alert_o is %b, expected %b", $time, got, exp);
    end
  endtask

  task automatic check_cfg(input scr_cfg_t got, input scr_cfg_t exp);
    check_cnt++;
    if (got !== exp) begin
      err_cnt++;
      $display("error at %0t ns: scr_cfg_o is %b/%h/%h, expected %b/%h/%h",
               $time, got.key_valid, got.key, got.nonce, exp.key_valid, exp.key, exp.nonce);
    end
  endtask

  ////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////

  // Register update at a clock edge, from the inputs held during the cycle
  task automatic update_model();
    logic req_next;
    req_next = model_req ? !stim.key_valid : stim.icache_inval;
    if (!model_req && stim.icache_inval) begin
      req_opened++;
    end
    if (stim.key_valid) begin
      if (model_req) begin
        keys_in_req++;
      end else begin
        keys_outside++;
      end
    end
    if (model_req) begin
      model_cfg.key_valid = stim.key_valid;
    end else if (stim.icache_inval) begin
      model_cfg.key_valid = 1'b0;
    end
    if (stim.key_valid) begin
      model_cfg.key   = stim.key;
      model_cfg.nonce = stim.nonce;
    end
    model_req    = req_next;
    model_busy_q = stim.core_busy;
  endtask

  task automatic check_outputs();
    logic   exp_sleep;
    logic   exp_clk_en;
    alert_t exp_alert;
    exp_sleep  = !(model_busy_q | stim.wake.debug_req | stim.wake.irq_pending | stim.wake.irq_nm);
    exp_clk_en = !exp_sleep | stim.test_en;
    exp_alert.minor          = stim.alert_minor | stim.lockstep_alert.minor;
    exp_alert.major_internal = stim.alert_major | stim.lockstep_alert.major_internal;
    exp_alert.major_bus      = stim.lockstep_alert.major_bus;
    check_bit(core_sleep, exp_sleep, "core_sleep_o");
    check_bit(clk_en, exp_clk_en, "clk_en_o");
    check_bit(scr_req, model_req, "scr_req_o");
    check_cfg(scr_cfg, model_cfg);
    check_alert(alert, exp_alert);
  endtask

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  function automatic stim_t idle_stim();
    stim_t s;
    s = '0;
    return s;
  endfunction

  // Rare invalidations and keys, busy and alerts toggle often
  task automatic make_random_stim(output stim_t s);
    logic [31:0] r;
    r = $random(seed);
    s = '0;
    s.core_busy           = r[0];
    s.wake.debug_req      = (r[3:1] == 3'd0);
    s.wake.irq_pending    = (r[6:4] == 3'd0);
    s.wake.irq_nm         = (r[10:7] == 4'd0);
    s.test_en             = (r[13:11] == 3'd0);
    s.icache_inval        = (r[17:14] == 4'd0);
    s.key_valid           = (r[21:18] == 4'd0);
    s.alert_minor         = r[22];
    s.alert_major         = r[23];
    s.lockstep_alert      = r[26:24];
    s.key   = {$random(seed), $random(seed), $random(seed), $random(seed)};
    s.nonce = {$random(seed), $random(seed)};
  endtask

  // One cycle: model edge, new inputs, check at the falling edge
  task automatic apply_cycle(input stim_t nxt);
    @(posedge clk_i);
    if (rst_ni) begin
      update_model();
    end
    stim <= nxt;
    @(negedge clk_i);
    check_outputs();
  endtask

  ////////////////////////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    stim_t s;
    rst_ni       = 1'b0;
    stim         = idle_stim();
    model_busy_q = 1'b0;
    model_req    = 1'b0;
    model_cfg    = '{key_valid: 1'b1, key: SCR_KEY_RST, nonce: SCR_NONCE_RST};

    repeat (RESET_CYCLES) @(posedge clk_i);
    rst_ni <= 1'b1;
    @(negedge clk_i);
    // Reset values with idle inputs
    check_bit(scr_req, 1'b0, "scr_req_o after reset");
    check_cfg(scr_cfg, '{key_valid: 1'b1, key: SCR_KEY_RST, nonce: SCR_NONCE_RST});
    check_bit(core_sleep, 1'b1, "core_sleep_o after reset");
    check_outputs();

    // Invalidation opens a request that waits for a key
    s = idle_stim();
    s.icache_inval = 1'b1;
    apply_cycle(s);
    repeat (4) apply_cycle(idle_stim());
    check_bit(scr_req, 1'b1, "scr_req_o while waiting for a key");
    check_bit(scr_cfg.key_valid, 1'b0, "key_valid while waiting for a key");

    // Requested key arrives
    s = idle_stim();
    s.key_valid = 1'b1;
    s.key       = {$random(seed), $random(seed), $random(seed), $random(seed)};
    s.nonce     = {$random(seed), $random(seed)};
    apply_cycle(s);
    repeat (2) apply_cycle(idle_stim());
    check_bit(scr_req, 1'b0, "scr_req_o after key arrival");
    check_bit(scr_cfg.key_valid, 1'b1, "key_valid after key arrival");

    // Unrequested key, then busy and wake causes one at a time
    s.key = ~s.key;
    apply_cycle(s);
    s = idle_stim();
    s.core_busy = 1'b1;
    apply_cycle(s);
    apply_cycle(idle_stim());
    s = idle_stim();
    s.wake.irq_nm = 1'b1;
    s.test_en     = 1'b1;
    apply_cycle(s);
    repeat (DIRECTED_CYCLES - 12) apply_cycle(idle_stim());

    for (int n = 0; n < RUN_CYCLES; n++) begin
      make_random_stim(s);
      apply_cycle(s);
    end
    apply_cycle(idle_stim());

    if (req_opened == 0 || keys_in_req == 0 || keys_outside == 0) begin
      err_cnt++;
      $display("key exchange not fully exercised: %0d requests, %0d requested keys, %0d others",
               req_opened, keys_in_req, keys_outside);
    end

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Run limit
  always @(posedge clk_i) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= TIMEOUT_CYCLES) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

endmodule

/* testbench/tb_clock_gen.sv */
// Testbench clock source
// Free running clock with a 20 ns period

`timescale 1ns/1ps

module tb_clock_gen (
  output logic clk_o
);

  localparam time HALF_PERIOD = 10ns;

  initial begin
    clk_o = 1'b0;
    forever begin
      #(HALF_PERIOD);
      clk_o = ~clk_o;
    end
  end

endmodule

/* logic/core_shell_top.sv */
// Core shell top level
// Wake control and scrambling key control instances,
// merge of core and lockstep alerts

`timescale 1ns/1ps

module core_shell_top (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // Core side
  input  logic                       core_busy_i,
  input  core_shell_pkg::wake_t      wake_i,
  input  logic                       test_en_i,
  input  logic                       icache_inval_i,
  input  logic                       core_alert_minor_i,
  input  logic                       core_alert_major_i,
  input  core_shell_pkg::alert_t     lockstep_alert_i,

  // Key provider
  input  logic                       scr_key_valid_i,
  input  core_shell_pkg::scr_key_t   scr_key_i,
  input  core_shell_pkg::scr_nonce_t scr_nonce_i,

  // Status
  output logic                       clk_en_o,
  output logic                       core_sleep_o,
  output logic                       scr_req_o,
  output core_shell_pkg::scr_cfg_t   scr_cfg_o,
  output core_shell_pkg::alert_t     alert_o
);

  ////////////////////////////////////////////////////////////
  // Wake control
  ////////////////////////////////////////////////////////////

  core_wake_ctrl u_core_wake_ctrl (
    .clk_i       (clk_i),
    .rst_ni      (rst_ni),
    .core_busy_i (core_busy_i),
    .wake_i      (wake_i),
    .test_en_i   (test_en_i),
    .clk_en_o    (clk_en_o),
    .core_sleep_o(core_sleep_o)
  );

  ////////////////////////////////////////////////////////////
  // Scrambling key control
  ////////////////////////////////////////////////////////////

  icache_scramble_ctrl u_icache_scramble_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .icache_inval_i (icache_inval_i),
    .scr_key_valid_i(scr_key_valid_i),
    .scr_key_i      (scr_key_i),
    .scr_nonce_i    (scr_nonce_i),
    .scr_req_o      (scr_req_o),
    .scr_cfg_o      (scr_cfg_o)
  );

  ////////////////////////////////////////////////////////////
  // Alert merge
  ////////////////////////////////////////////////////////////

  assign alert_o.minor          = core_alert_minor_i | lockstep_alert_i.minor;
  assign alert_o.major_internal = core_alert_major_i | lockstep_alert_i.major_internal;

  // The core has no bus alert of its own
  assign alert_o.major_bus      = lockstep_alert_i.major_bus;

  // Alerts leave the shell clean once out of reset
  a_alert_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(alert_o)
  ) else $error("alert output unknown");

endmodule

/* logic/icache_scramble_ctrl.sv */
// Instruction cache scrambling key control
// Key request FSM, key-valid tracking and key and nonce registers
// loaded from the key provider

`timescale 1ns/1ps

module icache_scramble_ctrl (
  input  logic                       clk_i,
  input  logic                       rst_ni,

  // From the cache
  input  logic                       icache_inval_i,

  // Key provider
  input  logic                       scr_key_valid_i,
  input  core_shell_pkg::scr_key_t   scr_key_i,
  input  core_shell_pkg::scr_nonce_t scr_nonce_i,
  output logic                       scr_req_o,

  // To the cache RAMs
  output core_shell_pkg::scr_cfg_t   scr_cfg_o
);

  import core_shell_pkg::*;

  scr_state_e state_d, state_q;
  logic       req_open;
  logic       key_valid_d, key_valid_q;
  scr_key_t   key_q;
  scr_nonce_t nonce_q;

  ////////////////////////////////////////////////////////////
  // Key request FSM
  ////////////////////////////////////////////////////////////

  assign req_open = (state_q == SCR_REQ);

  // Opened by an invalidation, closed by the first valid key
  always_comb begin
    state_d = state_q;
    case (state_q)
      SCR_IDLE: begin
        if (icache_inval_i) begin
          state_d = SCR_REQ;
        end
      end
      SCR_REQ: begin
        if (scr_key_valid_i) begin
          state_d = SCR_IDLE;
        end
      end
    endcase
  end

  ////////////////////////////////////////////////////////////
  // Key valid tracking
  ////////////////////////////////////////////////////////////

  // Valid from reset until the cache invalidates, back once a requested key lands
  always_comb begin
    if (req_open) begin
      key_valid_d = scr_key_valid_i;
    end else if (icache_inval_i) begin
      key_valid_d = 1'b0;
    end else begin
      key_valid_d = key_valid_q;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= SCR_IDLE;
      key_valid_q <= 1'b1;
    end else begin
      state_q     <= state_d;
      key_valid_q <= key_valid_d;
    end
  end

  ////////////////////////////////////////////////////////////
  // Key and nonce
  ////////////////////////////////////////////////////////////

  // Any valid key from the provider is taken, requested or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      key_q   <= SCR_KEY_RST;
      nonce_q <= SCR_NONCE_RST;
    end else if (scr_key_valid_i) begin
      key_q   <= scr_key_i;
      nonce_q <= scr_nonce_i;
    end
  end

  assign scr_req_o = req_open;

  assign scr_cfg_o = '{key_valid: key_valid_q, key: key_q, nonce: nonce_q};

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // A request is only dropped once the provider answered
  a_req_fall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(scr_req_o) |-> $past(scr_key_valid_i)
  ) else $error("key request dropped without a valid key");

  // Key valid only drops on invalidation or an unanswered request
  a_key_valid_fall: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    $fell(scr_cfg_o.key_valid) |-> $past(icache_inval_i || scr_req_o)
  ) else $error("key valid dropped without cause");

endmodule

/* logic/core_wake_ctrl.sv */
// Core wake control
// Registered busy flag, clock enable with test bypass and sleep indication

`timescale 1ns/1ps

module core_wake_ctrl (
  input  logic                  clk_i,
  input  logic                  rst_ni,

  input  logic                  core_busy_i,
  input  core_shell_pkg::wake_t wake_i,
  input  logic                  test_en_i,

  output logic                  clk_en_o,
  output logic                  core_sleep_o
);

  logic core_busy_q;
  logic wake_any;
  logic run_en;

  ////////////////////////////////////////////////////////////
  // Busy register
  ////////////////////////////////////////////////////////////

  // The core's own request to sleep lands one cycle late
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      core_busy_q <= 1'b0;
    end else begin
      core_busy_q <= core_busy_i;
    end
  end

  ////////////////////////////////////////////////////////////
  // Clock enable
  ////////////////////////////////////////////////////////////

  // Wake causes bypass the register
  assign wake_any = wake_i.debug_req | wake_i.irq_pending | wake_i.irq_nm;

  assign run_en       = core_busy_q | wake_any;
  assign core_sleep_o = ~run_en;

  // Test mode keeps the clock running, sleep state still reported
  assign clk_en_o = run_en | test_en_i;

  ////////////////////////////////////////////////////////////
  // Assertions
  ////////////////////////////////////////////////////////////

  // An awake core never sees its clock stopped
  a_awake_clk_en: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !core_sleep_o |-> clk_en_o
  ) else $error("clock enable low while core awake");

endmodule

/* logic/core_shell_pkg.sv */
// Shared definitions for the core shell
// Scrambling key and nonce widths, vector types and reset defaults,
// alert and wake cause structs, key request state encoding

package core_shell_pkg;

  ////////////////////////////////////////////////////////////
  // Scrambling key and nonce
  ////////////////////////////////////////////////////////////

  localparam int unsigned SCR_KEY_W   = 128;
  localparam int unsigned SCR_NONCE_W = 64;

  typedef logic [SCR_KEY_W-1:0]   scr_key_t;
  typedef logic [SCR_NONCE_W-1:0] scr_nonce_t;

  // Values used until the provider delivers a first key
  localparam scr_key_t   SCR_KEY_RST   = 128'h3a5c_91e7_0d4b_f26a_8c17_e5d9_4b02_a7f3;
  localparam scr_nonce_t SCR_NONCE_RST = 64'h6f1d_c83a_95b2_07e4;

  // Configuration seen by the cache RAMs
  typedef struct packed {
    logic       key_valid;
    scr_key_t   key;
    scr_nonce_t nonce;
  } scr_cfg_t;

  // Key request state
  typedef enum logic {
    SCR_IDLE = 1'b0,
    SCR_REQ  = 1'b1
  } scr_state_e;

  ////////////////////////////////////////////////////////////
  // Alerts and wake causes
  ////////////////////////////////////////////////////////////

  typedef struct packed {
    logic minor;
    logic major_internal;
    logic major_bus;
  } alert_t;

  // Asynchronous causes that reopen the core clock
  typedef struct packed {
    logic debug_req;
    logic irq_pending;
    logic irq_nm;
  } wake_t;

endpackage
